// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tcp_conn_tb and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tcp_conn_tb -f tcp_conn_top.f -o sim_tcp
	-./obj_dir/sim_tcp > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== tcp_conn_top.f ====
verilog/tcp_pkg.sv
verilog/tcp_conn_fsm.sv
verilog/tcp_retry_timer.sv
verilog/tcp_seg_launcher.sv
verilog/tcp_conn_top.sv
verification/tcp_conn_properties.sv
verification/tcp_conn_tb.sv

// ==== verification/tcp_conn_properties.sv ====
`timescale 1ns/1ps

module tcp_conn_properties (
    input logic clk,
    input logic rst_n,
    input logic tx_req,
    input logic tx_ack,
    input logic sender_start,
    input logic resp_valid,
    input logic resp_ready
);

    int fail_count = 0;                     // Read by the testbench at the end

    // ----------------------------------------
    // Outer handshakes
    // ----------------------------------------
    start_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        sender_start |=> !sender_start)
        else begin
            fail_count++;
            $error("sender_start lasted longer than one cycle");
        end

    resp_held: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid)
        else begin
            fail_count++;
            $error("resp_valid dropped before resp_ready");
        end

    // Four-phase order between FSM and launcher
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(tx_ack) |-> tx_req)
        else begin
            fail_count++;
            $error("tx_ack rose without tx_req");
        end

    req_waits_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(tx_req) |-> tx_ack)
        else begin
            fail_count++;
            $error("tx_req fell before tx_ack");
        end

endmodule

// ==== verification/tcp_conn_tb.sv ====
`timescale 1ns/1ps

module tcp_conn_tb;

    localparam logic [31:0] ISN = 32'hFFFF_F800;   // Close to wrap, sends roll over
    localparam int RTO        = 40;
    localparam int TW_CYCLES  = 60;
    localparam int RETRIES    = 3;
    localparam int N_SENDS    = 6;
    localparam int STALL_MAX  = 3;
    // Command to start, guard, busy, response stall and the four-phase return
    localparam int LAUNCH_MAX = 2 + 2 + 9 + 1 + STALL_MAX + 4;
    localparam int N_LAUNCH   = 2 + N_SENDS + 2 + (RETRIES + 1) + 1 + 4;
    localparam int LIMIT      = 4 * (16 + N_LAUNCH * LAUNCH_MAX + (RETRIES + 2) * RTO
                                     + TW_CYCLES + 40);

    localparam logic [7:0] F_FIN = 8'd1 << tcp_pkg::FLAG_FIN;
    localparam logic [7:0] F_SYN = 8'd1 << tcp_pkg::FLAG_SYN;
    localparam logic [7:0] F_RST = 8'd1 << tcp_pkg::FLAG_RST;
    localparam logic [7:0] F_PSH = 8'd1 << tcp_pkg::FLAG_PSH;
    localparam logic [7:0] F_ACK = 8'd1 << tcp_pkg::FLAG_ACK;

    logic        clk;
    logic        rst_n;
    logic        cmd_valid, cmd_ready;
    logic [7:0]  cmd_data;
    logic        resp_valid, resp_ready;
    logic [7:0]  resp_data;
    logic [15:0] payload_len;
    logic        sender_start, sender_busy;
    logic [31:0] seg_seq, seg_ack;
    logic [7:0]  seg_flags;
    logic [15:0] seg_len;
    logic        meta_valid, meta_ready;
    logic [31:0] meta_seq, meta_ack;
    logic [7:0]  meta_flags;

    logic [15:0] lfsr = 16'd53904;
    logic [87:0] seg_q[$];                  // {seq, ack, flags, len} per sender_start
    logic [7:0]  resp_q[$];
    logic [31:0] exp_snd, exp_rcv;          // Peer model view of both sequence spaces
    int          value_errs = 0;
    int          proto_errs = 0;

    tcp_conn_top #(
        .INIT_SEQ         (ISN),
        .RTO_CYCLES       (RTO),
        .TIME_WAIT_CYCLES (TW_CYCLES),
        .MAX_RETRIES      (RETRIES)
    ) DUT (.*);

    bind tcp_seg_launcher tcp_conn_properties u_props (
        .clk          (clk),
        .rst_n        (rst_n),
        .tx_req       (tx_req),
        .tx_ack       (tx_ack),
        .sender_start (sender_start),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
        end
        return v;
    endfunction

    // ----------------------------------------
    // Sender, response sink and monitor
    // ----------------------------------------
    initial begin : sender_model
        int n;
        sender_busy = 1'b0;
        forever begin
            @(negedge clk);
            if (sender_start) begin
                n = 1 + rand_bits(3);       // 1 to 8 busy cycles
                @(posedge clk);
                sender_busy <= 1'b1;
                repeat (n) @(posedge clk);
                sender_busy <= 1'b0;
            end
        end
    end

    initial begin : ready_model
        int low_run;
        resp_ready = 1'b0;
        low_run    = 0;
        forever begin
            @(posedge clk);
            if (low_run < STALL_MAX && rand_bits(1) == 0) begin
                resp_ready <= 1'b0;
                low_run++;
            end else begin
                resp_ready <= 1'b1;
                low_run = 0;
            end
        end
    end

    initial begin : monitor
        forever begin
            @(negedge clk);
            if (sender_start) seg_q.push_back({seg_seq, seg_ack, seg_flags, seg_len});
            if (resp_valid && resp_ready) resp_q.push_back(resp_data);
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the tests were still running after %0d cycles", LIMIT);
        $display("Result: FAILED");
        $finish;
    end

    // ----------------------------------------
    // Drivers and checks
    // ----------------------------------------
    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is %h, expected %h", $time, name, got, exp);
            value_errs++;
        end
    endtask

    task automatic issue_cmd(input tcp_pkg::cmd_op_e op, input logic [15:0] len);
        @(posedge clk);
        cmd_valid   <= 1'b1;
        cmd_data    <= op;
        payload_len <= len;
        do begin
            @(negedge clk);
        end while (!cmd_ready);
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic drive_meta(input logic [31:0] seq, input logic [31:0] ack,
                              input logic [7:0] flags);
        @(posedge clk);
        meta_valid <= 1'b1;
        meta_seq   <= seq;
        meta_ack   <= ack;
        meta_flags <= flags;
        do begin
            @(negedge clk);
        end while (!meta_ready);
        @(posedge clk);
        meta_valid <= 1'b0;
    endtask

    // One emitted segment and its response beat
    task automatic expect_launch(input logic [31:0] seq, input logic [31:0] ack,
                                 input logic [7:0] flags, input logic [15:0] len,
                                 input tcp_pkg::conn_state_e code);
        logic [87:0] s;
        logic [7:0]  r;
        while (seg_q.size() == 0) @(negedge clk);
        s = seg_q.pop_front();
        compare_field("seg_seq", s[87:56], seq);
        compare_field("seg_ack", s[55:24], ack);
        compare_field("seg_flags", 32'(s[23:16]), 32'(flags));
        compare_field("seg_len", 32'(s[15:0]), 32'(len));
        while (resp_q.size() == 0) @(negedge clk);
        r = resp_q.pop_front();
        compare_field("resp_data", 32'(r), 32'(code));
    endtask

    task automatic wait_cmd_ready(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!cmd_ready);
    endtask

    task automatic open_conn();
        logic [31:0] peer_isn;
        issue_cmd(tcp_pkg::CMD_CONNECT, 16'd0);
        expect_launch(ISN, 32'd0, F_SYN, 16'd0, tcp_pkg::SYN_SENT);
        exp_snd  = ISN + 1;
        peer_isn = rand_bits(32);
        drive_meta(peer_isn, ISN + 1, F_SYN | F_ACK);
        exp_rcv  = peer_isn + 1;
        expect_launch(exp_snd, exp_rcv, F_ACK, 16'd0, tcp_pkg::ESTABLISHED);
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin : stimulus
        logic [15:0] len;
        int          waited;
        int          assert_errs;
        rst_n       = 1'b0;
        cmd_valid   = 1'b0;
        cmd_data    = '0;
        payload_len = '0;
        meta_valid  = 1'b0;
        meta_seq    = '0;
        meta_ack    = '0;
        meta_flags  = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        if (sender_start || resp_valid || meta_ready) begin
            $display("Outputs were not idle right after reset");
            proto_errs++;
        end
        @(negedge clk);
        if (!cmd_ready) begin
            $display("cmd_ready did not rise in the first cycle after reset");
            proto_errs++;
        end

        open_conn();

        repeat (N_SENDS) begin              // Seq advances by each payload
            len = 16'(rand_bits(12));
            issue_cmd(tcp_pkg::CMD_SEND, len);
            expect_launch(exp_snd, exp_rcv, F_ACK | F_PSH, len, tcp_pkg::ESTABLISHED);
            exp_snd = exp_snd + 32'(len);
        end

        // Active close through FIN_WAIT_2
        issue_cmd(tcp_pkg::CMD_CLOSE, 16'd0);
        expect_launch(exp_snd, exp_rcv, F_FIN | F_ACK, 16'd0, tcp_pkg::FIN_WAIT_1);
        exp_snd = exp_snd + 1;
        drive_meta(exp_rcv, exp_snd, F_ACK);
        drive_meta(exp_rcv, exp_snd, F_FIN | F_ACK);
        expect_launch(exp_snd, exp_rcv + 1, F_ACK, 16'd0, tcp_pkg::TIME_WAIT);
        wait_cmd_ready(waited);
        if (waited < TW_CYCLES) begin
            $display("TIME_WAIT ended after %0d cycles, too early", waited);
            proto_errs++;
        end

        // Unanswered CONNECT until retries run out
        issue_cmd(tcp_pkg::CMD_CONNECT, 16'd0);
        wait_cmd_ready(waited);
        if (seg_q.size() != RETRIES + 1) begin
            $display("Expected %0d SYN segments before giving up, saw %0d",
                     RETRIES + 1, seg_q.size());
            proto_errs++;
        end
        while (seg_q.size() > 0) expect_launch(ISN, 32'd0, F_SYN, 16'd0, tcp_pkg::SYN_SENT);

        // Second attempt refused by RST
        issue_cmd(tcp_pkg::CMD_CONNECT, 16'd0);
        expect_launch(ISN, 32'd0, F_SYN, 16'd0, tcp_pkg::SYN_SENT);
        drive_meta(rand_bits(32), 32'd0, F_RST);
        wait_cmd_ready(waited);
        if (seg_q.size() != 0) begin
            $display("RST in SYN_SENT did not stop the SYN retransmissions");
            proto_errs++;
        end

        // SEND is illegal in CLOSED and must leave no segment
        issue_cmd(tcp_pkg::CMD_SEND, 16'd5);
        open_conn();

        // Passive close
        drive_meta(exp_rcv, exp_snd, F_FIN | F_ACK);
        exp_rcv = exp_rcv + 1;
        expect_launch(exp_snd, exp_rcv, F_ACK, 16'd0, tcp_pkg::CLOSE_WAIT);
        issue_cmd(tcp_pkg::CMD_CLOSE, 16'd0);
        expect_launch(exp_snd, exp_rcv, F_FIN | F_ACK, 16'd0, tcp_pkg::LAST_ACK);
        exp_snd = exp_snd + 1;
        drive_meta(exp_rcv, exp_snd, F_ACK);
        wait_cmd_ready(waited);

        if (seg_q.size() != 0 || resp_q.size() != 0) begin
            $display("Unexpected extra segments or responses at the end of the run");
            proto_errs++;
        end

        assert_errs = DUT.u_launcher.u_props.fail_count;
        $display("Errors: %0d value, %0d protocol, %0d assertion",
                 value_errs, proto_errs, assert_errs);
        if (value_errs + proto_errs + assert_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/tcp_conn_fsm.sv ====
`timescale 1ns/1ps

module tcp_conn_fsm #(
    parameter logic [tcp_pkg::SEQ_W-1:0] INIT_SEQ = 32'h12345678
)(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cmd_valid,
    input  logic [tcp_pkg::CMD_W-1:0]   cmd_data,
    output logic                        cmd_ready,
    input  logic [tcp_pkg::LEN_W-1:0]   payload_len,
    input  logic                        meta_valid,
    output logic                        meta_ready,
    input  logic [tcp_pkg::SEQ_W-1:0]   meta_seq,
    input  logic [tcp_pkg::SEQ_W-1:0]   meta_ack,
    input  logic [tcp_pkg::FLAGS_W-1:0] meta_flags,
    output logic [tcp_pkg::SEQ_W-1:0]   seg_seq,
    output logic [tcp_pkg::SEQ_W-1:0]   seg_ack,
    output logic [tcp_pkg::FLAGS_W-1:0] seg_flags,
    output logic [tcp_pkg::LEN_W-1:0]   seg_len,
    output logic                        tx_req,
    output tcp_pkg::conn_state_e        tx_code,
    input  logic                        tx_ack,
    output logic                        tmr_load,
    output tcp_pkg::timer_mode_e        tmr_mode,
    output logic                        tmr_retry,
    output logic                        tmr_stop,
    input  logic                        tmr_expired,
    input  logic                        tmr_exhausted
);

    tcp_pkg::conn_state_e         state, state_d, new_code;
    logic [tcp_pkg::SEQ_W-1:0]    snd_nxt, rcv_nxt;       // Our next seq, peer's next seq
    logic [tcp_pkg::SEQ_W-1:0]    snd_d, rcv_d;
    logic [tcp_pkg::SEQ_W-1:0]    new_seq, new_ack;
    logic [tcp_pkg::SEQ_W-1:0]    peer_next;
    logic [tcp_pkg::FLAGS_W-1:0]  new_flags;
    logic [tcp_pkg::LEN_W-1:0]    new_len;
    logic                         go, resend, retx, pend_d;
    logic                         cmd_take, meta_take;
    logic                         is_fin, is_syn, is_rst, is_ack;

    // tx_req stays high for the whole launch and blocks intake
    assign cmd_take  = cmd_valid && cmd_ready;
    assign meta_ready = (state inside {tcp_pkg::SYN_SENT, tcp_pkg::ESTABLISHED,
                                      tcp_pkg::FIN_WAIT_1, tcp_pkg::FIN_WAIT_2,
                                      tcp_pkg::LAST_ACK}) && !tx_req && !cmd_take;
    assign meta_take = meta_valid && meta_ready;

    assign is_fin    = meta_flags[tcp_pkg::FLAG_FIN];
    assign is_syn    = meta_flags[tcp_pkg::FLAG_SYN];
    assign is_rst    = meta_flags[tcp_pkg::FLAG_RST];
    assign is_ack    = meta_flags[tcp_pkg::FLAG_ACK];
    assign peer_next = meta_seq + 1'b1;     // SYN and FIN take one sequence number

    // ----------------------------------------
    // Next state and segment selection
    // ----------------------------------------
    always_comb begin
        go        = 1'b0;
        resend    = 1'b0;
        new_seq   = snd_nxt;
        new_ack   = rcv_nxt;
        new_flags = '0;
        new_flags[tcp_pkg::FLAG_ACK] = 1'b1;    // Nearly every segment carries ACK
        new_len   = '0;
        new_code  = state;
        snd_d     = snd_nxt;
        rcv_d     = rcv_nxt;
        state_d   = state;

        if (tx_req) begin
            if (tx_ack) state_d = tx_code;      // Launch done, enter reported state
        end else if (cmd_take) begin
            case (cmd_data)
                tcp_pkg::CMD_CONNECT: if (state == tcp_pkg::CLOSED) begin
                    go        = 1'b1;
                    new_seq   = INIT_SEQ;
                    new_ack   = '0;
                    new_flags = '0;
                    new_flags[tcp_pkg::FLAG_SYN] = 1'b1;
                    new_code  = tcp_pkg::SYN_SENT;
                    snd_d     = INIT_SEQ + 1'b1;
                end
                tcp_pkg::CMD_SEND: if (state == tcp_pkg::ESTABLISHED) begin
                    go       = 1'b1;
                    new_flags[tcp_pkg::FLAG_PSH] = 1'b1;
                    new_len  = payload_len;
                    snd_d    = snd_nxt + tcp_pkg::SEQ_W'(payload_len);
                end
                tcp_pkg::CMD_CLOSE: begin
                    if (state == tcp_pkg::ESTABLISHED || state == tcp_pkg::CLOSE_WAIT) begin
                        go       = 1'b1;
                        new_flags[tcp_pkg::FLAG_FIN] = 1'b1;
                        new_code = (state == tcp_pkg::ESTABLISHED) ? tcp_pkg::FIN_WAIT_1
                                                                   : tcp_pkg::LAST_ACK;
                        snd_d    = snd_nxt + 1'b1;
                    end
                end
                default: ;                      // Unknown opcode is dropped
            endcase
        end else if (meta_take) begin
            case (state)
                tcp_pkg::SYN_SENT: begin
                    if (is_rst) begin
                        state_d = tcp_pkg::CLOSED;
                    end else if (is_syn && is_ack && meta_ack == INIT_SEQ + 1'b1) begin
                        go       = 1'b1;
                        new_ack  = peer_next;
                        rcv_d    = peer_next;
                        new_code = tcp_pkg::ESTABLISHED;
                    end
                end
                tcp_pkg::ESTABLISHED: begin
                    if (is_rst) begin
                        state_d = tcp_pkg::CLOSED;
                    end else if (is_fin) begin  // Passive close
                        go       = 1'b1;
                        new_ack  = peer_next;
                        rcv_d    = peer_next;
                        new_code = tcp_pkg::CLOSE_WAIT;
                    end
                end
                tcp_pkg::FIN_WAIT_1: begin
                    if (is_ack && meta_ack == snd_nxt) begin
                        if (is_fin) begin       // Simultaneous close
                            go       = 1'b1;
                            new_ack  = peer_next;
                            rcv_d    = peer_next;
                            new_code = tcp_pkg::TIME_WAIT;
                        end else begin
                            state_d = tcp_pkg::FIN_WAIT_2;
                        end
                    end
                end
                tcp_pkg::FIN_WAIT_2: begin
                    if (is_fin) begin
                        go       = 1'b1;
                        new_ack  = peer_next;
                        rcv_d    = peer_next;
                        new_code = tcp_pkg::TIME_WAIT;
                    end
                end
                tcp_pkg::LAST_ACK: begin
                    if (is_ack && meta_ack == snd_nxt) state_d = tcp_pkg::CLOSED;
                end
                default: ;
            endcase
        end

        // Timeouts only act when nothing else moved the connection
        if (!tx_req && !go && state_d == state && tmr_expired) begin
            if (state inside {tcp_pkg::SYN_SENT, tcp_pkg::FIN_WAIT_1, tcp_pkg::LAST_ACK}) begin
                if (tmr_exhausted) state_d = tcp_pkg::CLOSED;   // Give up
                else               resend  = 1'b1;
            end else if (state == tcp_pkg::TIME_WAIT) begin
                state_d = tcp_pkg::CLOSED;
            end
        end

        pend_d = go || resend || (tx_req && !tx_ack);
    end

    // Timer control, started once the segment has gone out
    always_comb begin
        tmr_load  = 1'b0;
        tmr_retry = 1'b0;
        tmr_stop  = 1'b0;
        tmr_mode  = tcp_pkg::TMR_RTO;
        if (tx_req && tx_ack) begin
            case (tx_code)
                tcp_pkg::SYN_SENT, tcp_pkg::FIN_WAIT_1, tcp_pkg::LAST_ACK: begin
                    tmr_retry = retx;
                    tmr_load  = !retx;
                end
                tcp_pkg::TIME_WAIT: begin
                    tmr_load = 1'b1;
                    tmr_mode = tcp_pkg::TMR_TIME_WAIT;
                end
                default: tmr_stop = 1'b1;
            endcase
        end else if (state_d != state) begin
            tmr_stop = 1'b1;
        end
    end

    // ----------------------------------------
    // Registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= tcp_pkg::CLOSED;
            snd_nxt   <= '0;
            rcv_nxt   <= '0;
            tx_req    <= 1'b0;
            tx_code   <= tcp_pkg::CLOSED;
            retx      <= 1'b0;
            cmd_ready <= 1'b0;
        end else begin
            state   <= state_d;
            snd_nxt <= snd_d;
            rcv_nxt <= rcv_d;
            tx_req  <= pend_d;
            if (go) tx_code <= new_code;        // A resend keeps the previous code
            if (go || resend) retx <= resend;
            cmd_ready <= (state_d inside {tcp_pkg::CLOSED, tcp_pkg::ESTABLISHED,
                                          tcp_pkg::CLOSE_WAIT}) && !pend_d && !cmd_take;
        end
    end

    // Segment fields, held until the next launch
    always_ff @(posedge clk) begin
        if (go) begin
            seg_seq   <= new_seq;
            seg_ack   <= new_ack;
            seg_flags <= new_flags;
            seg_len   <= new_len;
        end
    end

endmodule

// ==== verilog/tcp_conn_top.sv ====
`timescale 1ns/1ps

module tcp_conn_top #(
    parameter logic [tcp_pkg::SEQ_W-1:0] INIT_SEQ = 32'h12345678,
    parameter int RTO_CYCLES       = 200,
    parameter int TIME_WAIT_CYCLES = 400,
    parameter int MAX_RETRIES      = 3
)(
    input  logic                        clk,
    input  logic                        rst_n,

    // Application commands and responses
    input  logic                        cmd_valid,
    input  logic [tcp_pkg::CMD_W-1:0]   cmd_data,
    output logic                        cmd_ready,
    output logic                        resp_valid,
    output logic [tcp_pkg::CMD_W-1:0]   resp_data,
    input  logic                        resp_ready,
    input  logic [tcp_pkg::LEN_W-1:0]   payload_len,

    // Outer segment sender
    output logic                        sender_start,
    input  logic                        sender_busy,
    output logic [tcp_pkg::SEQ_W-1:0]   seg_seq,
    output logic [tcp_pkg::SEQ_W-1:0]   seg_ack,
    output logic [tcp_pkg::FLAGS_W-1:0] seg_flags,
    output logic [tcp_pkg::LEN_W-1:0]   seg_len,

    // Parsed segments from the peer
    input  logic                        meta_valid,
    output logic                        meta_ready,
    input  logic [tcp_pkg::SEQ_W-1:0]   meta_seq,
    input  logic [tcp_pkg::SEQ_W-1:0]   meta_ack,
    input  logic [tcp_pkg::FLAGS_W-1:0] meta_flags
);

    logic                 tx_req;
    logic                 tx_ack;
    tcp_pkg::conn_state_e tx_code;
    logic                 tmr_load;
    logic                 tmr_retry;
    logic                 tmr_stop;
    tcp_pkg::timer_mode_e tmr_mode;
    logic                 tmr_expired;
    logic                 tmr_exhausted;

    tcp_conn_fsm #(
        .INIT_SEQ (INIT_SEQ)
    ) u_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_valid     (cmd_valid),
        .cmd_data      (cmd_data),
        .cmd_ready     (cmd_ready),
        .payload_len   (payload_len),
        .meta_valid    (meta_valid),
        .meta_ready    (meta_ready),
        .meta_seq      (meta_seq),
        .meta_ack      (meta_ack),
        .meta_flags    (meta_flags),
        .seg_seq       (seg_seq),
        .seg_ack       (seg_ack),
        .seg_flags     (seg_flags),
        .seg_len       (seg_len),
        .tx_req        (tx_req),
        .tx_code       (tx_code),
        .tx_ack        (tx_ack),
        .tmr_load      (tmr_load),
        .tmr_mode      (tmr_mode),
        .tmr_retry     (tmr_retry),
        .tmr_stop      (tmr_stop),
        .tmr_expired   (tmr_expired),
        .tmr_exhausted (tmr_exhausted)
    );

    tcp_retry_timer #(
        .RTO_CYCLES       (RTO_CYCLES),
        .TIME_WAIT_CYCLES (TIME_WAIT_CYCLES),
        .MAX_RETRIES      (MAX_RETRIES)
    ) u_timer (
        .clk           (clk),
        .rst_n         (rst_n),
        .tmr_load      (tmr_load),
        .tmr_mode      (tmr_mode),
        .tmr_retry     (tmr_retry),
        .tmr_stop      (tmr_stop),
        .tmr_expired   (tmr_expired),
        .tmr_exhausted (tmr_exhausted)
    );

    tcp_seg_launcher u_launcher (
        .clk          (clk),
        .rst_n        (rst_n),
        .tx_req       (tx_req),
        .tx_code      (tx_code),
        .tx_ack       (tx_ack),
        .sender_start (sender_start),
        .sender_busy  (sender_busy),
        .resp_valid   (resp_valid),
        .resp_data    (resp_data),
        .resp_ready   (resp_ready)
    );

endmodule

// ==== verilog/tcp_pkg.sv ====
package tcp_pkg;

    // ----------------------------------------
    // Field widths
    // ----------------------------------------
    parameter int SEQ_W   = 32;
    parameter int LEN_W   = 16;
    parameter int FLAGS_W = 8;
    parameter int CMD_W   = 8;

    // ----------------------------------------
    // TCP flag bit positions
    // ----------------------------------------
    parameter int FLAG_FIN = 0;
    parameter int FLAG_SYN = 1;
    parameter int FLAG_RST = 2;
    parameter int FLAG_PSH = 3;
    parameter int FLAG_ACK = 4;

    // Application command opcodes
    typedef enum logic [CMD_W-1:0] {
        CMD_CONNECT = 8'd1,
        CMD_CLOSE   = 8'd2,
        CMD_SEND    = 8'd3
    } cmd_op_e;

    // Connection states, also reported in each response beat
    typedef enum logic [3:0] {
        CLOSED      = 4'd0,
        SYN_SENT    = 4'd1,
        ESTABLISHED = 4'd2,
        FIN_WAIT_1  = 4'd3,
        FIN_WAIT_2  = 4'd4,
        CLOSE_WAIT  = 4'd5,
        LAST_ACK    = 4'd6,
        TIME_WAIT   = 4'd7
    } conn_state_e;

    typedef enum logic {
        TMR_RTO,
        TMR_TIME_WAIT
    } timer_mode_e;

endpackage

// ==== verilog/tcp_retry_timer.sv ====
`timescale 1ns/1ps

module tcp_retry_timer #(
    parameter int RTO_CYCLES       = 200,
    parameter int TIME_WAIT_CYCLES = 400,
    parameter int MAX_RETRIES      = 3
)(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 tmr_load,
    input  tcp_pkg::timer_mode_e tmr_mode,
    input  logic                 tmr_retry,
    input  logic                 tmr_stop,
    output logic                 tmr_expired,
    output logic                 tmr_exhausted
);

    localparam int MAX_CYCLES = (TIME_WAIT_CYCLES > RTO_CYCLES) ? TIME_WAIT_CYCLES
                                                                : RTO_CYCLES;
    localparam int CNT_W = $clog2(MAX_CYCLES + 1);
    localparam int RTY_W = $clog2(MAX_RETRIES + 2);

    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] reload;
    logic [RTY_W-1:0] retries;
    logic             running;

    assign reload = (tmr_mode == tcp_pkg::TMR_TIME_WAIT) ? CNT_W'(TIME_WAIT_CYCLES - 1)
                                                         : CNT_W'(RTO_CYCLES - 1);

    assign tmr_expired   = running && count == '0;      // Single cycle, timer idles after
    assign tmr_exhausted = retries >= RTY_W'(MAX_RETRIES);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count   <= '0;
            running <= 1'b0;
            retries <= '0;
        end else begin
            if (tmr_stop) begin
                running <= 1'b0;
            end else if (tmr_load || tmr_retry) begin
                running <= 1'b1;
                count   <= reload;
            end else if (running) begin
                if (count == '0) running <= 1'b0;
                else             count   <= count - 1'b1;
            end

            // Retry count restarts with each fresh load
            if (tmr_load)                         retries <= '0;
            else if (tmr_retry && !tmr_exhausted) retries <= retries + 1'b1;
        end
    end

endmodule

// ==== verilog/tcp_seg_launcher.sv ====
`timescale 1ns/1ps

module tcp_seg_launcher (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      tx_req,
    input  tcp_pkg::conn_state_e      tx_code,
    output logic                      tx_ack,
    output logic                      sender_start,
    input  logic                      sender_busy,
    output logic                      resp_valid,
    output logic [tcp_pkg::CMD_W-1:0] resp_data,
    input  logic                      resp_ready
);

    typedef enum logic [2:0] {
        L_IDLE,
        L_START,
        L_BUSY,
        L_RESP,
        L_ACK
    } launch_state_e;

    launch_state_e lstate;

    // ----------------------------------------
    // Launch sequence
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lstate       <= L_IDLE;
            sender_start <= 1'b0;
            resp_valid   <= 1'b0;
            tx_ack       <= 1'b0;
        end else begin
            sender_start <= 1'b0;
            case (lstate)
                L_IDLE: begin
                    if (tx_req) begin
                        sender_start <= 1'b1;
                        lstate       <= L_START;
                    end
                end
                // Guard cycle while the sender picks up the pulse
                L_START: lstate <= L_BUSY;
                L_BUSY: begin
                    if (!sender_busy) begin
                        resp_valid <= 1'b1;
                        lstate     <= L_RESP;
                    end
                end
                L_RESP: begin
                    if (resp_ready) begin
                        resp_valid <= 1'b0;
                        tx_ack     <= 1'b1;     // Beat taken, acknowledge the FSM
                        lstate     <= L_ACK;
                    end
                end
                L_ACK: begin
                    if (!tx_req) begin          // Four-phase return to zero
                        tx_ack <= 1'b0;
                        lstate <= L_IDLE;
                    end
                end
                default: lstate <= L_IDLE;
            endcase
        end
    end

    // Response carries the state being entered
    always_ff @(posedge clk) begin
        if (lstate == L_BUSY && !sender_busy) resp_data <= tcp_pkg::CMD_W'(tx_code);
    end

endmodule
